/* Makefile */
# Verilator simulation of the instruction cache prefetch front end

VERILATOR ?= verilator
TOP       ?= tb_icache_pf
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
hw/icache_pf_pkg.sv
hw/next_line_prefetcher.sv
hw/line_tag_store.sv
hw/fill_arbiter.sv
hw/icache_pf_top.sv
testbench/icache_pf_assertions.sv
testbench/tb_icache_pf.sv

/* hw/fill_arbiter.sv */
// Fill arbiter: demand over prefetch onto one memory port, tracks the outstanding fill
`timescale 1ns/1ps

module fill_arbiter
  import icache_pf_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fill_req_t  demand_req_i,     // From the tag store
  input  fill_req_t  prefetch_req_i,   // From the prefetcher
  input  logic       mem_busy_i,       // Memory working
  input  logic       mem_fill_done_i,  // Fill complete pulse
  output logic       demand_ack_o,     // Demand issued this cycle
  output logic       prefetch_ack_o,   // Prefetch issued this cycle
  output logic       cache_busy_o,     // Hold-off toward the prefetcher
  output logic       mem_req_o,        // Request pulse
  output mem_req_t   mem_req_data_o,   // Line and source of the request
  output logic       fill_o,           // Install pulse toward the tag store
  output line_addr_t fill_line_o       // Line to install
);

  // ==============================
  // Grant logic
  // ==============================
  logic       can_issue;
  logic       demand_grant;
  logic       prefetch_grant;
  logic       out_vld_q;      // One fill in flight
  line_addr_t out_line_q;     // Line of the fill in flight

  // Port free only with memory idle and nothing outstanding
  assign can_issue = !mem_busy_i && !out_vld_q;

  // Demand always first
  assign demand_grant   = can_issue && demand_req_i.valid;
  assign prefetch_grant = can_issue && prefetch_req_i.valid && !demand_req_i.valid;

  assign demand_ack_o   = demand_grant;
  assign prefetch_ack_o = prefetch_grant;
  assign mem_req_o      = demand_grant || prefetch_grant;

  // Mux follows the same priority as the grant
  always_comb begin
    if (demand_req_i.valid) begin
      mem_req_data_o.line        = demand_req_i.line;
      mem_req_data_o.is_prefetch = 1'b0;
    end else begin
      mem_req_data_o.line        = prefetch_req_i.line;
      mem_req_data_o.is_prefetch = 1'b1;
    end
  end

  // Demand still waiting, or memory occupied
  assign cache_busy_o = (demand_req_i.valid && !demand_grant) || mem_busy_i;

  // ==============================
  // Outstanding fill
  // ==============================

  // Done with nothing outstanding is ignored
  assign fill_o      = mem_fill_done_i && out_vld_q;
  assign fill_line_o = out_line_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_vld_q <= 1'b0;
    end else if (mem_req_o) begin
      out_vld_q <= 1'b1;       // Cannot coincide with done, port was free
    end else if (mem_fill_done_i) begin
      out_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_req_o) begin
      out_line_q <= mem_req_data_o.line;
    end
  end

endmodule

/* hw/icache_pf_pkg.sv */
// Instruction cache prefetch front end shared geometry and request types
package icache_pf_pkg;

  // ==============================
  // Line geometry
  // ==============================
  localparam int ADDR_W     = 32;                    // Byte address width
  localparam int LINE_BYTES = 16;                    // Bytes per cache line
  localparam int OFFSET_W   = $clog2(LINE_BYTES);    // Byte offset inside a line
  localparam int NUM_SETS   = 16;                    // Direct-mapped sets
  localparam int INDEX_W    = $clog2(NUM_SETS);      // Set index bits
  localparam int LINE_W     = ADDR_W - OFFSET_W;     // Line number width, 28
  localparam int TAG_W      = LINE_W - INDEX_W;      // Tag above the index, 24

  // Line number, byte address without offset bits
  typedef logic [LINE_W-1:0] line_addr_t;

  // ==============================
  // Request types
  // ==============================

  // Fill request from either source into the arbiter
  // Demand side from the tag store, prefetch side from the prefetcher
  typedef struct packed {
    logic       valid;  // Request level, held until acknowledged
    line_addr_t line;   // Line to fetch
  } fill_req_t;

  // Request as seen by the memory port
  typedef struct packed {
    line_addr_t line;         // Line to fetch
    logic       is_prefetch;  // Set when the prefetch side won
  } mem_req_t;

endpackage

/* hw/icache_pf_top.sv */
// Instruction cache front end top: tag store, next-line prefetcher and fill arbiter
`timescale 1ns/1ps

module icache_pf_top
  import icache_pf_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              lookup_i,
  input  logic [ADDR_W-1:0] lookup_addr_i,
  input  logic              mem_busy_i,
  input  logic              mem_fill_done_i,
  output logic              hit_o,
  output logic              miss_o,
  output logic              mem_req_o,
  output mem_req_t          mem_req_data_o
);

  // ==============================
  // Internal nets
  // ==============================
  fill_req_t  demand_req;      // Tag store to arbiter
  fill_req_t  prefetch_req;    // Prefetcher to arbiter
  logic       demand_ack;
  logic       prefetch_ack;
  logic       cache_busy;      // Arbiter to prefetcher
  logic       fill;            // Install pulse
  line_addr_t fill_line;
  line_addr_t miss_line;       // Tag store to prefetcher
  logic       prefetch_valid;  // Prefetch level, watched by bound checks

  assign prefetch_valid = prefetch_req.valid;

  // ==============================
  // Blocks
  // ==============================
  line_tag_store i_line_tag_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .lookup_i      (lookup_i),
    .lookup_addr_i (lookup_addr_i),
    .fill_i        (fill),
    .fill_line_i   (fill_line),
    .demand_ack_i  (demand_ack),
    .hit_o         (hit_o),
    .miss_o        (miss_o),
    .miss_line_o   (miss_line),
    .demand_req_o  (demand_req)
  );

  // Same miss pulse drives both the demand and the prefetch
  next_line_prefetcher i_next_line_prefetcher (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .cache_miss_i   (miss_o),
    .miss_addr_i    (miss_line),
    .prefetch_ack_i (prefetch_ack),
    .cache_busy_i   (cache_busy),
    .prefetch_o     (prefetch_req)
  );

  fill_arbiter i_fill_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .demand_req_i    (demand_req),
    .prefetch_req_i  (prefetch_req),
    .mem_busy_i      (mem_busy_i),
    .mem_fill_done_i (mem_fill_done_i),
    .demand_ack_o    (demand_ack),
    .prefetch_ack_o  (prefetch_ack),
    .cache_busy_o    (cache_busy),
    .mem_req_o       (mem_req_o),
    .mem_req_data_o  (mem_req_data_o),
    .fill_o          (fill),
    .fill_line_o     (fill_line)
  );

endmodule

/* hw/line_tag_store.sv */
// Direct-mapped line tag store with registered hit/miss lookup and fill install
`timescale 1ns/1ps

module line_tag_store
  import icache_pf_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,        // Invalidate all sets
  input  logic              lookup_i,       // Lookup strobe
  input  logic [ADDR_W-1:0] lookup_addr_i,  // Byte address to look up
  input  logic              fill_i,         // Install pulse from the arbiter
  input  line_addr_t        fill_line_i,    // Line being installed
  input  logic              demand_ack_i,   // Demand accepted by the arbiter
  output logic              hit_o,          // One cycle after lookup
  output logic              miss_o,         // One cycle after lookup
  output line_addr_t        miss_line_o,    // Line of the last lookup
  output fill_req_t         demand_req_o    // Demand fill, level until ack
);

  // ==============================
  // Storage
  // ==============================
  logic [TAG_W-1:0]    tag_q [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;

  // Lookup side split
  line_addr_t         lookup_line;
  logic [INDEX_W-1:0] lookup_idx;
  logic [TAG_W-1:0]   lookup_tag;
  logic               lookup_hit;
  logic               lookup_ok;     // Lookup not swallowed by flush

  // Fill side split
  logic [INDEX_W-1:0] fill_idx;
  logic [TAG_W-1:0]   fill_tag;

  logic               demand_vld_q;
  line_addr_t         demand_line_q;
  logic               demand_load;

  assign lookup_line = lookup_addr_i[ADDR_W-1:OFFSET_W];
  assign lookup_idx  = lookup_line[INDEX_W-1:0];
  assign lookup_tag  = lookup_line[LINE_W-1:INDEX_W];
  assign lookup_hit  = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign lookup_ok   = lookup_i && !flush_i;

  assign fill_idx = fill_line_i[INDEX_W-1:0];
  assign fill_tag = fill_line_i[LINE_W-1:INDEX_W];

  // New demand only once the slot is free or drained this cycle
  assign demand_load = lookup_ok && !lookup_hit && (!demand_vld_q || demand_ack_i);

  assign demand_req_o.valid = demand_vld_q;
  assign demand_req_o.line  = demand_line_q;

  // ==============================
  // Tag and valid arrays
  // ==============================
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_q[fill_idx] <= fill_tag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;                 // Flush wins over a same-cycle install
    end else if (fill_i) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // ==============================
  // Lookup result and demand
  // ==============================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_o        <= 1'b0;
      miss_o       <= 1'b0;
      demand_vld_q <= 1'b0;
    end else begin
      hit_o  <= lookup_ok && lookup_hit;
      miss_o <= lookup_ok && !lookup_hit;
      if (flush_i) begin
        demand_vld_q <= 1'b0;
      end else if (demand_load) begin
        demand_vld_q <= 1'b1;
      end else if (demand_ack_i) begin
        demand_vld_q <= 1'b0;
      end
    end
  end

  // Line payloads
  always_ff @(posedge clk_i) begin
    if (lookup_ok) begin
      miss_line_o <= lookup_line;
    end
    if (demand_load) begin
      demand_line_q <= lookup_line;
    end
  end

endmodule

/* hw/next_line_prefetcher.sv */
// Next-line prefetcher: turns a new cache miss into a request for the following line
`timescale 1ns/1ps

module next_line_prefetcher
  import icache_pf_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,         // Cancels any pending prefetch
  input  logic       cache_miss_i,    // Miss pulse from the tag store
  input  line_addr_t miss_addr_i,     // Line that missed
  input  logic       prefetch_ack_i,  // Arbiter took the request
  input  logic       cache_busy_i,    // Demand waiting or memory working
  output fill_req_t  prefetch_o       // Prefetch request toward the arbiter
);

  // ==============================
  // State machine
  // ==============================
  typedef enum logic [1:0] {
    IDLE,      // No prefetch outstanding
    PENDING,   // Request offered to the arbiter
    WAIT_ACK   // Held back while the cache is busy
  } state_e;

  state_e state_q, state_d;

  // ==============================
  // Registers
  // ==============================
  line_addr_t pf_line_q;      // Line to be prefetched
  line_addr_t last_miss_q;    // Most recent miss that started a prefetch
  logic       last_vld_q;     // last_miss_q holds a real line

  logic       is_new_miss;
  logic       start_pf;
  line_addr_t next_line;

  // Following aligned line, wraps at the top of the space
  assign next_line = miss_addr_i + line_addr_t'(1);

  // Same line twice in a row gives no second prefetch
  assign is_new_miss = !last_vld_q || (miss_addr_i != last_miss_q);

  // Capture only from idle and only while the cache can take it
  assign start_pf = cache_miss_i && is_new_miss && !cache_busy_i &&
                    (state_q == IDLE) && !flush_i;

  // Request is live in both non-idle states
  assign prefetch_o.valid = (state_q == PENDING) || (state_q == WAIT_ACK);
  assign prefetch_o.line  = pf_line_q;

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_pf) begin
          state_d = PENDING;
        end
      end
      PENDING: begin
        if (flush_i) begin
          state_d = IDLE;
        end else if (prefetch_ack_i) begin
          state_d = IDLE;      // Arbiter issued it
        end else if (cache_busy_i) begin
          state_d = WAIT_ACK;  // Back off until the cache frees
        end
      end
      WAIT_ACK: begin
        if (flush_i || prefetch_ack_i) begin
          state_d = IDLE;
        end else if (!cache_busy_i) begin
          state_d = PENDING;   // Offer again
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ==============================
  // Sequential logic
  // ==============================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      last_vld_q <= 1'b0;
    end else begin
      state_q <= state_d;  // Flush handled in next state
      if (start_pf) begin
        last_vld_q <= 1'b1;
      end
    end
  end

  // Line payload, kept across flush
  always_ff @(posedge clk_i) begin
    if (start_pf) begin
      pf_line_q   <= next_line;
      last_miss_q <= miss_addr_i;
    end
  end

endmodule

/* testbench/icache_pf_assertions.sv */
// Bound checks on the front end memory request and prefetch signals
`timescale 1ns/1ps

module icache_pf_assertions
  import icache_pf_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      flush_i,
  input logic      mem_busy_i,
  input logic      mem_req_o,
  input mem_req_t  mem_req_data_o,
  input fill_req_t demand_req,
  input logic      prefetch_valid
);

  // Port only takes a request while memory is idle
  a_req_not_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_req_o |-> !mem_busy_i
  ) else $error("Memory request issued while memory busy");

  // A waiting demand keeps the offered line steady on the port
  a_req_line_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    demand_req.valid && !mem_req_o && !flush_i |=> $stable(mem_req_data_o)
  ) else $error("Memory request line changed while a demand waited");

  // Flush cancels the prefetch by the next cycle
  a_flush_drops_pf: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_i |=> !prefetch_valid
  ) else $error("Prefetch still valid the cycle after flush");

endmodule

/* testbench/tb_icache_pf.sv */
// Directed testbench for the instruction cache prefetch front end
`timescale 1ns/1ps

module tb_icache_pf
  import icache_pf_pkg::*;
();

  // ==============================
  // DUT signals and bookkeeping
  // ==============================
  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              flush_i;
  logic              lookup_i;
  logic [ADDR_W-1:0] lookup_addr_i;
  logic              mem_busy_i;
  logic              mem_fill_done_i;
  logic              hit_o;
  logic              miss_o;
  logic              mem_req_o;
  mem_req_t          mem_req_data_o;

  mem_req_t req_log[$];           // Requests seen by memory, oldest first
  logic     stall;                // Keeps memory busy past its latency
  int       seed = 8503;
  int       err_cnt = 0;
  int       timeout_cnt = 0;      // Waits in the test flow
  int       mem_timeout_cnt = 0;  // Waits in the memory model

  // Test addresses, distinct lines
  logic [ADDR_W-1:0] addr_a = 32'h0000_1230;
  logic [ADDR_W-1:0] addr_b = 32'h0000_9ab0;
  logic [ADDR_W-1:0] addr_c = 32'h0000_5670;
  logic [ADDR_W-1:0] addr_x = 32'h0000_4440;
  logic [ADDR_W-1:0] addr_y = 32'h0000_7770;

  always #20 clk_i = ~clk_i;  // 40 ns period

  icache_pf_top i_icache_pf_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .lookup_i        (lookup_i),
    .lookup_addr_i   (lookup_addr_i),
    .mem_busy_i      (mem_busy_i),
    .mem_fill_done_i (mem_fill_done_i),
    .hit_o           (hit_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_req_data_o  (mem_req_data_o)
  );

  bind icache_pf_top icache_pf_assertions i_icache_pf_assertions (.*);

  // ==============================
  // Memory model
  // ==============================
  initial begin : mem_model
    int lat;
    int guard;
    mem_busy_i      = 1'b0;
    mem_fill_done_i = 1'b0;
    forever begin
      @(negedge clk_i);                     // Request pulse is stable mid-cycle
      if (rst_ni && mem_req_o) begin
        req_log.push_back(mem_req_data_o);
        lat = 1 + int'($unsigned($random(seed)) % 6);  // 1 to 6 cycles
        @(posedge clk_i);
        #2 mem_busy_i = 1'b1;
        repeat (lat - 1) @(posedge clk_i);
        guard = 0;
        while (stall && guard < 400) begin  // Held by the test
          @(posedge clk_i);
          guard++;
        end
        if (guard >= 400) begin
          mem_timeout_cnt++;
          $display("Timeout: memory stall never released");
        end
        @(posedge clk_i);
        #2;
        mem_busy_i      = 1'b0;
        mem_fill_done_i = 1'b1;             // Done with busy already low
        @(posedge clk_i);
        #2 mem_fill_done_i = 1'b0;
      end
    end
  end

  // ==============================
  // Helpers
  // ==============================
  function automatic line_addr_t line_of(input logic [ADDR_W-1:0] addr);
    return addr[ADDR_W-1:OFFSET_W];  // Drop the byte offset
  endfunction

  task automatic check_lookup(input logic [ADDR_W-1:0] addr, input logic exp_hit);
    @(posedge clk_i);
    #2;
    lookup_i      = 1'b1;
    lookup_addr_i = addr;
    @(posedge clk_i);
    #2 lookup_i = 1'b0;
    @(negedge clk_i);  // Result pulse one cycle after the strobe
    assert (hit_o == exp_hit && miss_o == !exp_hit) else begin
      err_cnt++;
      $display("FAIL %0t: lookup %h expected %s, got hit=%b miss=%b", $time, addr,
               exp_hit ? "hit" : "miss", hit_o, miss_o);
    end
  endtask

  // Oldest logged request must match
  task automatic expect_req(input line_addr_t exp_line, input logic exp_pf);
    mem_req_t r;
    int       n;
    n = 0;
    while (req_log.size() == 0 && n < 100) begin
      @(posedge clk_i);
      n++;
    end
    if (req_log.size() == 0) begin
      timeout_cnt++;
      $display("Timeout: no memory request arrived for line %h", exp_line);
    end else begin
      r = req_log.pop_front();
      assert (r.line == exp_line && r.is_prefetch == exp_pf) else begin
        err_cnt++;
        $display("FAIL %0t: request line %h pf %b, expected line %h pf %b", $time,
                 r.line, r.is_prefetch, exp_line, exp_pf);
      end
    end
  endtask

  task automatic expect_log_empty();
    assert (req_log.size() == 0) else begin
      err_cnt++;
      $display("FAIL %0t: %0d unexpected memory requests", $time, req_log.size());
    end
  endtask

  // Memory port idle for 10 cycles in a row
  task automatic wait_quiet();
    int quiet;
    int n;
    quiet = 0;
    n     = 0;
    while (quiet < 10 && n < 400) begin
      @(negedge clk_i);
      if (mem_busy_i || mem_fill_done_i || mem_req_o) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      n++;
    end
    if (quiet < 10) begin
      timeout_cnt++;
      $display("Timeout: memory port never went quiet");
    end
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic test_idle_after_reset();
    repeat (20) begin
      @(negedge clk_i);
      assert (!mem_req_o && !hit_o && !miss_o) else begin
        err_cnt++;
        $display("FAIL %0t: activity without lookups req=%b hit=%b miss=%b", $time,
                 mem_req_o, hit_o, miss_o);
      end
    end
  endtask

  task automatic test_cold_miss();
    check_lookup(addr_a, 1'b0);
    expect_req(line_of(addr_a), 1'b0);               // Demand first
    expect_req(line_of(addr_a + LINE_BYTES), 1'b1);  // Then the next line
  endtask

  task automatic test_fill_then_hit();
    wait_quiet();
    check_lookup(addr_a, 1'b1);
    check_lookup(addr_a + LINE_BYTES, 1'b1);         // Filled by the prefetch
    check_lookup(addr_a + 2 * LINE_BYTES, 1'b0);
    wait_quiet();
    expect_req(line_of(addr_a + 2 * LINE_BYTES), 1'b0);
    expect_req(line_of(addr_a + 3 * LINE_BYTES), 1'b1);
    expect_log_empty();
  endtask

  task automatic test_repeat_miss();
    int         pf_cnt;
    line_addr_t pf_line;
    pf_cnt  = 0;
    pf_line = '0;
    check_lookup(addr_c, 1'b0);
    check_lookup(addr_c, 1'b0);  // Fill not installed yet
    wait_quiet();
    foreach (req_log[i]) begin
      if (req_log[i].is_prefetch) begin
        pf_cnt++;
        pf_line = req_log[i].line;
      end
    end
    assert (pf_cnt == 1 && pf_line == line_of(addr_c + LINE_BYTES)) else begin
      err_cnt++;
      $display("FAIL %0t: %0d prefetches for a repeated miss, last line %h", $time,
               pf_cnt, pf_line);
    end
    req_log.delete();
  endtask

  task automatic test_flush_drops_prefetch();
    int n;
    n     = 0;
    stall = 1'b1;
    check_lookup(addr_b, 1'b0);
    while (!(i_icache_pf_top.prefetch_valid && mem_busy_i) && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 50) begin
      timeout_cnt++;
      $display("Timeout: prefetch never pending while memory busy");
    end
    @(posedge clk_i);
    #2 flush_i = 1'b1;
    @(posedge clk_i);
    #2 flush_i = 1'b0;
    @(negedge clk_i);
    assert (!i_icache_pf_top.prefetch_valid) else begin
      err_cnt++;
      $display("FAIL %0t: prefetch still pending after flush", $time);
    end
    stall = 1'b0;
    wait_quiet();
    expect_req(line_of(addr_b), 1'b0);  // Only the demand already issued
    expect_log_empty();
    check_lookup(addr_a, 1'b0);         // Flushed lines are gone
    check_lookup(addr_a + LINE_BYTES, 1'b0);
    wait_quiet();
    req_log.delete();
  endtask

  task automatic test_demand_first();
    stall = 1'b1;
    check_lookup(addr_x, 1'b0);  // Demand out, prefetch held back
    check_lookup(addr_y, 1'b0);  // Second demand waits behind the fill
    stall = 1'b0;
    wait_quiet();
    expect_req(line_of(addr_x), 1'b0);
    expect_req(line_of(addr_y), 1'b0);
    expect_req(line_of(addr_x + LINE_BYTES), 1'b1);
    expect_log_empty();
  endtask

  // ==============================
  // Main flow
  // ==============================
  initial begin
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    lookup_i      = 1'b0;
    lookup_addr_i = '0;
    stall         = 1'b0;
    repeat (16) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    test_idle_after_reset();
    test_cold_miss();
    test_fill_then_hit();
    test_repeat_miss();
    test_flush_drops_prefetch();
    test_demand_first();
    $display("Checks done: %0d errors, %0d timeouts", err_cnt,
             timeout_cnt + mem_timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && mem_timeout_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    repeat (20000) @(posedge clk_i);
    $display("Timeout: run did not complete within the cycle limit");
    $display("Testbench failed");
    $finish;
  end

endmodule
